//--- design/sd_data_pkg.sv
// SD data path shared definitions

package sd_data_pkg;

  // ======================================================================
  // Block geometry
  // ======================================================================
  localparam int BLOCK_NIBBLES = 1024; // 512 bytes on four lines
  localparam int CRC_NIBBLES   = 16;   // One CRC-16 per line
  localparam int ADDR_W        = 10;

  // ======================================================================
  // CRC and scrambler constants
  // ======================================================================
  localparam logic [15:0] CRC16_POLY = 16'h1021; // x^16+x^12+x^5+1
  localparam logic [15:0] LFSR_TAPS  = 16'hB400; // Bits 15, 13, 12, 10

  typedef logic [3:0]        nibble_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Driver phases
  typedef enum logic [2:0] {
    IDLE      = 3'b000,
    WAIT_RCV  = 3'b001,
    RCV_DATA  = 3'b011,
    CHECK_CRC = 3'b010,
    WAIT_SEND = 3'b110,
    SEND_DATA = 3'b100,
    SEND_CRC  = 3'b101,
    BUSY      = 3'b111
  } drv_state_e;

endpackage

//--- design/nibble_ram_if.sv
// Nibble buffer port bundle

`timescale 1ns/1ps

interface nibble_ram_if
  import sd_data_pkg::*;
();

  addr_t   waddr;
  nibble_t wdata;
  logic    we;
  addr_t   raddr;
  nibble_t rdata; // Valid one clock after raddr

  // Writer side
  modport wr (output waddr, output wdata, output we);

  // Reader side
  modport rd (output raddr, input rdata);

  // Storage side
  modport mem (input waddr, input wdata, input we, input raddr, output rdata);

endinterface

//--- design/crc16_line.sv
// Per-line CRC-16 generator

`timescale 1ns/1ps

module crc16_line
  import sd_data_pkg::*;
(
  input  logic iclk,
  input  logic irst,    // Block clear
  input  logic idata,
  input  logic iunload,
  output logic ocrc
);

  logic [15:0] rem;
  logic        fb;

  assign fb   = idata ^ rem[15];
  assign ocrc = rem[15]; // MSB first on unload

  always_ff @(posedge iclk) begin
    if (irst) begin
      rem <= '0;
    end else if (iunload) begin
      rem <= {rem[14:0], 1'b0}; // Zeros fill behind
    end else if (fb) begin
      rem <= {rem[14:0], 1'b0} ^ CRC16_POLY;
    end else begin
      rem <= {rem[14:0], 1'b0};
    end
  end

endmodule

//--- design/nibble_ram.sv
// Block buffer RAM

`timescale 1ns/1ps

module nibble_ram
  import sd_data_pkg::*;
#(
  parameter int DEPTH = BLOCK_NIBBLES
)(
  input logic       iclk,
  nibble_ram_if.mem port
);

  nibble_t mem [DEPTH];

  // Write port
  always_ff @(posedge iclk) begin
    if (port.we) begin
      mem[port.waddr] <= port.wdata;
    end
  end

  // Registered read for block RAM mapping
  always_ff @(posedge iclk) begin
    port.rdata <= mem[port.raddr];
  end

endmodule

//--- design/d_line_driver.sv
// SD data line driver

`timescale 1ns/1ps

module d_line_driver
  import sd_data_pkg::*;
(
  input  logic     iclk,
  input  logic     irst,
  input  nibble_t  idata_sd,
  output nibble_t  odata_sd,
  input  logic     istart_read,
  input  logic     istart_write,
  nibble_ram_if.wr rx,
  nibble_ram_if.rd tx,
  output logic     rx_ok,
  output logic     ocrc_fail,
  output logic     odone
);

  drv_state_e state;
  addr_t      counter;  // Shared by all phases
  nibble_t    rx_nib;   // Sampled line nibble
  nibble_t    tx_nib;   // Line output register
  nibble_t    crc_in;
  nibble_t    crc_out;
  logic       crc_clr;
  logic       unload;

  // ======================================================================
  // CRC engines, one per line
  // ======================================================================
  assign crc_clr = irst || !(state == RCV_DATA || state == CHECK_CRC ||
                             state == SEND_DATA || state == SEND_CRC);
  assign unload  = (state == CHECK_CRC) || (state == SEND_CRC);
  assign crc_in  = (state == SEND_DATA) ? tx.rdata : rx_nib; // Fold what goes out

  for (genvar i = 0; i < 4; i++) begin : g_crc
    crc16_line u_crc (
      .iclk    (iclk),
      .irst    (crc_clr),
      .idata   (crc_in[i]),
      .iunload (unload),
      .ocrc    (crc_out[i])
    );
  end

  // Buffer ports
  assign rx.waddr = counter;
  assign rx.wdata = rx_nib;
  assign rx.we    = (state == RCV_DATA);
  assign tx.raddr = (state == SEND_DATA) ? counter + addr_t'(1) : '0; // One ahead

  assign odata_sd = tx_nib;
  assign odone    = (state == IDLE) || (state == WAIT_SEND);

  always_ff @(posedge iclk) begin
    rx_nib <= idata_sd;
  end

  // Start nibble, data, CRC, then idle high
  always_ff @(posedge iclk) begin
    if (irst) begin
      tx_nib <= 4'hF;
    end else if (state == WAIT_SEND && istart_write) begin
      tx_nib <= 4'h0;
    end else if (state == SEND_DATA) begin
      tx_nib <= tx.rdata;
    end else if (state == SEND_CRC && counter < addr_t'(CRC_NIBBLES)) begin
      tx_nib <= crc_out;
    end else begin
      tx_nib <= 4'hF; // End nibble and idle level
    end
  end

  // ======================================================================
  // Main FSM
  // ======================================================================
  always_ff @(posedge iclk) begin
    if (irst) begin
      state     <= IDLE;
      counter   <= '0;
      rx_ok     <= 1'b0;
      ocrc_fail <= 1'b0;
    end else begin
      rx_ok <= 1'b0;
      case (state)
        IDLE: begin
          if (istart_read) begin
            state     <= WAIT_RCV;
            counter   <= '0;
            ocrc_fail <= 1'b0;
          end
        end
        WAIT_RCV: begin
          if (rx_nib == 4'h0) begin // Start nibble seen
            state   <= RCV_DATA;
            counter <= '0;
          end
        end
        RCV_DATA: begin
          counter <= counter + addr_t'(1);
          if (counter == addr_t'(BLOCK_NIBBLES - 1)) begin
            state   <= CHECK_CRC;
            counter <= '0;
          end
        end
        CHECK_CRC: begin
          counter <= counter + addr_t'(1);
          if (crc_out != rx_nib) begin
            state     <= IDLE;
            ocrc_fail <= 1'b1;
          end else if (counter == addr_t'(CRC_NIBBLES - 1)) begin
            state <= WAIT_SEND;
            rx_ok <= 1'b1; // Kicks off the scrambler
          end
        end
        WAIT_SEND: begin
          if (istart_write) begin
            state   <= SEND_DATA;
            counter <= '0;
          end
        end
        SEND_DATA: begin
          counter <= counter + addr_t'(1);
          if (counter == addr_t'(BLOCK_NIBBLES - 1)) begin
            state   <= SEND_CRC;
            counter <= '0;
          end
        end
        SEND_CRC: begin
          counter <= counter + addr_t'(1);
          if (counter == addr_t'(CRC_NIBBLES)) begin // End nibble loaded
            state <= BUSY;
          end
        end
        BUSY: begin
          if (idata_sd[0]) begin // Card released D0
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- design/nibble_scrambler.sv
// LFSR nibble scrambler

`timescale 1ns/1ps

module nibble_scrambler
  import sd_data_pkg::*;
(
  input  logic        iclk,
  input  logic        irst,
  input  logic        istart,
  input  logic [15:0] ikey,
  nibble_ram_if.rd    rx,
  nibble_ram_if.wr    tx,
  output logic        oready
);

  logic [15:0] lfsr;
  logic        fb;
  addr_t       rd_addr;
  addr_t       wr_addr;  // Address of the nibble now on rdata
  logic        reading;
  logic        wr_valid;
  logic        busy;

  assign fb = ^(lfsr & LFSR_TAPS);

  assign rx.raddr = rd_addr;
  assign tx.waddr = wr_addr;
  assign tx.wdata = rx.rdata ^ lfsr[3:0]; // Keystream is the low nibble
  assign tx.we    = wr_valid;
  assign oready   = !busy;

  // Read sweep and write pipeline
  always_ff @(posedge iclk) begin
    if (irst) begin
      reading  <= 1'b0;
      wr_valid <= 1'b0;
      busy     <= 1'b0;
      rd_addr  <= '0;
    end else if (istart) begin
      reading  <= 1'b1;
      wr_valid <= 1'b0;
      busy     <= 1'b1;
      rd_addr  <= '0;
    end else begin
      wr_valid <= reading;
      if (reading) begin
        rd_addr <= rd_addr + addr_t'(1);
        if (rd_addr == addr_t'(BLOCK_NIBBLES - 1)) begin
          reading <= 1'b0;
        end
      end
      if (wr_valid && wr_addr == addr_t'(BLOCK_NIBBLES - 1)) begin
        busy <= 1'b0; // Last nibble written
      end
    end
  end

  always_ff @(posedge iclk) begin
    wr_addr <= rd_addr;
    if (istart) begin
      lfsr <= ikey;
    end else if (wr_valid) begin
      lfsr <= {lfsr[14:0], fb}; // Step after each nibble
    end
  end

endmodule

//--- design/sd_data_top.sv
// SD data path top level

`timescale 1ns/1ps

module sd_data_top
  import sd_data_pkg::*;
(
  input  logic        iclk,
  input  logic        irst,
  input  nibble_t     idata_sd,
  output nibble_t     odata_sd,
  input  logic        istart_read,
  input  logic        istart_write,
  input  logic [15:0] ikey,
  output logic        ocrc_fail,
  output logic        odone,
  output logic        oready
);

  logic rx_ok;

  nibble_ram_if rx_if ();  // Received block
  nibble_ram_if tx_if ();  // Scrambled block

  nibble_ram #(.DEPTH(BLOCK_NIBBLES)) u_rx_ram (
    .iclk (iclk),
    .port (rx_if.mem)
  );

  nibble_ram #(.DEPTH(BLOCK_NIBBLES)) u_tx_ram (
    .iclk (iclk),
    .port (tx_if.mem)
  );

  d_line_driver u_driver (
    .iclk         (iclk),
    .irst         (irst),
    .idata_sd     (idata_sd),
    .odata_sd     (odata_sd),
    .istart_read  (istart_read),
    .istart_write (istart_write),
    .rx           (rx_if.wr),
    .tx           (tx_if.rd),
    .rx_ok        (rx_ok),
    .ocrc_fail    (ocrc_fail),
    .odone        (odone)
  );

  nibble_scrambler u_scrambler (
    .iclk   (iclk),
    .irst   (irst),
    .istart (rx_ok),
    .ikey   (ikey),
    .rx     (rx_if.rd),
    .tx     (tx_if.wr),
    .oready (oready)
  );

endmodule

//--- dv/sd_data_tb.sv
// SD data path testbench

`timescale 1ns/1ps

module sd_data_tb
  import sd_data_pkg::*;
();

  localparam int LINE_LEN   = BLOCK_NIBBLES + CRC_NIBBLES + 1; // Data, CRC, end nibble
  localparam int MAX_CYCLES = 10000; // Three blocks of about 2100 cycles plus margin

  logic        iclk = 1'b0;
  logic        irst;
  nibble_t     idata_sd;
  nibble_t     odata_sd;
  logic        istart_read;
  logic        istart_write;
  logic [15:0] ikey;
  logic        ocrc_fail;
  logic        odone;
  logic        oready;
  logic [31:0] rng;
  nibble_t     blk [BLOCK_NIBBLES];  // Block sent by the card model
  nibble_t     exp_line [LINE_LEN];  // Expected transmit after the start nibble
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          tx_count = 0;

  sd_data_top dut0 (.*);

  always #4 iclk = ~iclk;

  always @(posedge iclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles with %0d errors", MAX_CYCLES, errors);
      $display("tests failed");
      $finish;
    end
  end

  // ====================================================================
  // Reference models
  // ====================================================================
  function automatic logic lfsr_bit();
    logic fb;
    fb  = rng[31] ^ rng[21] ^ rng[1] ^ rng[0];
    rng = {rng[30:0], fb};
    return fb;
  endfunction

  // One line bit into a CRC-16 in MSB-first order
  function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic b);
    return {crc[14:0], 1'b0} ^ ((b ^ crc[15]) ? CRC16_POLY : 16'h0000);
  endfunction

  function automatic logic [15:0] key_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic void build_expected(input logic [15:0] key);
    logic [15:0] s;
    logic [15:0] crc [4];
    s   = key;
    crc = '{default: 16'h0000};
    for (int i = 0; i < BLOCK_NIBBLES; i++) begin
      exp_line[i] = blk[i] ^ s[3:0]; // Keystream is the low nibble
      s = key_step(s);
      for (int k = 0; k < 4; k++) begin
        crc[k] = crc_step(crc[k], exp_line[i][k]);
      end
    end
    for (int i = 0; i < CRC_NIBBLES; i++) begin
      for (int k = 0; k < 4; k++) begin
        exp_line[BLOCK_NIBBLES + i][k] = crc[k][15 - i];
      end
    end
    exp_line[LINE_LEN - 1] = 4'hF;
  endfunction

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // odone follows the driver phase
  task automatic check_state(input string name, input drv_state_e phase, input logic exp);
    checks++;
    if (odone !== exp) begin
      errors++;
      $display("error %s: expected odone %b in %s, actual %b", name, exp, phase.name(), odone);
    end
  endtask

  task automatic wait_ready(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (oready !== level && n < limit) begin
      @(negedge iclk);
      n++;
    end
    if (oready !== level) begin
      errors++;
      $display("%s", what);
    end
  endtask

  // ====================================================================
  // Card model
  // ====================================================================
  task automatic send_block(input logic [15:0] key, input int flip_nib);
    logic [15:0] crc [4];
    nibble_t     nib;
    crc = '{default: 16'h0000};
    for (int i = 0; i < BLOCK_NIBBLES; i++) begin
      blk[i] = {lfsr_bit(), lfsr_bit(), lfsr_bit(), lfsr_bit()};
    end
    ikey = key;
    @(negedge iclk);
    istart_read = 1'b1;
    @(negedge iclk);
    istart_read = 1'b0;
    idata_sd    = 4'h0; // Start nibble
    for (int i = 0; i < BLOCK_NIBBLES; i++) begin
      @(negedge iclk);
      idata_sd = blk[i];
      for (int k = 0; k < 4; k++) begin
        crc[k] = crc_step(crc[k], blk[i][k]);
      end
    end
    for (int i = 0; i < CRC_NIBBLES; i++) begin
      for (int k = 0; k < 4; k++) begin
        nib[k] = crc[k][15 - i];
      end
      if (i == flip_nib) begin
        nib[2] = ~nib[2];
      end
      @(negedge iclk);
      idata_sd = nib;
    end
    @(negedge iclk);
    idata_sd = 4'hF; // End bits
  endtask

  task automatic transmit_block(input string tag);
    int seen;
    int n;
    seen = tx_count;
    n    = 0;
    @(negedge iclk);
    istart_write = 1'b1;
    idata_sd     = 4'hE; // Busy low on D0
    @(negedge iclk);
    istart_write = 1'b0;
    check_state({tag, " send"}, SEND_DATA, 1'b0);
    while (tx_count == seen && n < LINE_LEN + 8) begin
      @(negedge iclk);
      n++;
    end
    if (tx_count == seen) begin
      errors++;
      $display("%s: transmit block never started on the data lines", tag);
    end
    repeat (16) begin
      @(negedge iclk);
      check_state({tag, " busy"}, BUSY, 1'b0);
    end
    idata_sd = 4'hF;
    @(negedge iclk);
    check_state({tag, " busy release"}, IDLE, 1'b1);
  endtask

  // Captures the transmit stream behind each start nibble
  initial begin
    forever begin
      @(negedge iclk);
      if (irst === 1'b0 && odata_sd === 4'h0) begin
        for (int i = 0; i < LINE_LEN; i++) begin
          @(negedge iclk);
          check_nibble($sformatf("tx nibble %0d", i), exp_line[i], odata_sd);
        end
        tx_count++;
      end
    end
  end

  initial begin
    irst         = 1'b1;
    idata_sd     = 4'hF;
    istart_read  = 1'b0;
    istart_write = 1'b0;
    ikey         = 16'h0000;
    rng          = 32'h7d1532f9;
    repeat (8) @(negedge iclk);
    irst = 1'b0;
    @(negedge iclk);
    check_nibble("reset odata_sd", 4'hF, odata_sd);
    check_bit("reset oready", 1'b1, oready);
    check_bit("reset ocrc_fail", 1'b0, ocrc_fail);
    check_state("reset odone", IDLE, 1'b1);

    send_block(16'hACE1, -1);
    build_expected(16'hACE1);
    wait_ready(1'b0, 8, "block 1: oready did not fall after a good block");
    wait_ready(1'b1, BLOCK_NIBBLES + 16, "block 1: oready did not rise after scrambling");
    check_bit("block 1 ocrc_fail", 1'b0, ocrc_fail);
    check_state("block 1 odone", WAIT_SEND, 1'b1);
    transmit_block("block 1");

    send_block(16'h1234, 5); // One CRC bit flipped
    repeat (32) begin
      @(negedge iclk);
      check_bit("block 2 oready", 1'b1, oready);
    end
    check_bit("block 2 ocrc_fail", 1'b1, ocrc_fail);
    check_state("block 2 odone", IDLE, 1'b1);

    send_block(16'h3C5A, -1);
    build_expected(16'h3C5A);
    wait_ready(1'b0, 8, "block 3: oready did not fall after a good block");
    wait_ready(1'b1, BLOCK_NIBBLES + 16, "block 3: oready did not rise after scrambling");
    check_bit("block 3 ocrc_fail", 1'b0, ocrc_fail);
    check_state("block 3 odone", WAIT_SEND, 1'b1);
    transmit_block("block 3");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/sd_data_pkg.sv
design/nibble_ram_if.sv
design/crc16_line.sv
design/nibble_ram.sv
design/d_line_driver.sv
design/nibble_scrambler.sv
design/sd_data_top.sv
dv/sd_data_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SD data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module sd_data_tb -o sim_sd_data
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_sd_data > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0
